// ==== Makefile ====
# Verilator build and run for the camera capture block

VERILATOR ?= verilator
TOP       ?= camera_tb
RTL_TOP   ?= camera
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails on a nonzero exit status or on the fail message in the log
run: build
	@./$(SIM_EXE) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
camera_pkg.sv
frame_crop.sv
pixel_packer.sv
image_buffer.sv
capture_ctrl.sv
camera.sv
camera_tb.sv

// ==== camera.sv ====
`timescale 1ns/1ps

module camera import camera_pkg::*; (
    input  logic          clock_spi_in,
    input  logic          mipi_byte_reset_n,
    input  pixel_stream_t pixel_i,
    input  byte_t         op_code_i,
    input  logic          op_code_valid_i,
    input  logic          operand_valid_i,
    input  int            operand_count_i,
    output byte_t         response_o,
    output logic          response_valid_o
);

    pixel_stream_t cropped_pixel;
    buffer_write_t buffer_write;
    buffer_addr_t  read_address;
    byte_t         read_data;
    logic          capture_active;

    frame_crop frame_crop (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel_i),
        .pixel_o           (cropped_pixel)
    );

    pixel_packer pixel_packer (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (cropped_pixel),
        .capture_active_i  (capture_active),
        .write_o           (buffer_write)
    );

    image_buffer image_buffer (
        .clock_spi_in   (clock_spi_in),
        .write_i        (buffer_write),
        .read_address_i (read_address),
        .read_data_o    (read_data)
    );

    capture_ctrl capture_ctrl (
        .clock_spi_in          (clock_spi_in),
        .mipi_byte_reset_n     (mipi_byte_reset_n),
        .op_code_i             (op_code_i),
        .op_code_valid_i       (op_code_valid_i),
        .operand_valid_i       (operand_valid_i),
        .operand_count_i       (operand_count_i),
        .cropped_frame_valid_i (cropped_pixel.frame_valid),
        .read_data_i           (read_data),
        .read_address_o        (read_address),
        .capture_active_o      (capture_active),
        .response_o            (response_o),
        .response_valid_o      (response_valid_o)
    );

endmodule

// ==== camera_pkg.sv ====
package camera_pkg;

    // Widths with a meaning of their own
    typedef logic [9:0]  color_t;        // One colour channel
    typedef logic [7:0]  byte_t;         // Command, response or buffer byte
    typedef logic [15:0] buffer_addr_t;  // Buffer address or byte count

    // Debayered pixel with its frame timing levels
    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
        logic   line_valid;
        logic   frame_valid;
    } pixel_stream_t;

    // Write port request into the image buffer
    typedef struct packed {
        logic         enable;
        buffer_addr_t address;
        byte_t        data;
    } buffer_write_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ARMED,
        CTRL_CAPTURING
    } ctrl_state_t;

    // Crop window, half open, in columns and lines
    localparam logic [15:0] CROP_X_START = 16'd8;
    localparam logic [15:0] CROP_X_END   = 16'd24;
    localparam logic [15:0] CROP_Y_START = 16'd6;
    localparam logic [15:0] CROP_Y_END   = 16'd22;

    // One RGB332 byte per cropped pixel
    localparam buffer_addr_t CAPTURE_SIZE =
        buffer_addr_t'((CROP_X_END - CROP_X_START) * (CROP_Y_END - CROP_Y_START));

    localparam int BUFFER_ADDR_BITS = $clog2(CAPTURE_SIZE);

    // Host opcodes
    localparam byte_t OP_CAPTURE         = 8'h20;
    localparam byte_t OP_BYTES_AVAILABLE = 8'h21;
    localparam byte_t OP_READ_DATA       = 8'h22;

endpackage

// ==== camera_tb.sv ====
`timescale 1ns/1ps

module camera_tb import camera_pkg::*; ();

    localparam int FRAME_WIDTH      = 40;
    localparam int FRAME_HEIGHT     = 30;
    localparam int RESPONSE_TIMEOUT = 32;   // Cycles allowed for a response edge

    typedef logic [BUFFER_ADDR_BITS-1:0] index_t;   // Position inside one cropped frame

    logic          clock_spi_in;
    logic          mipi_byte_reset_n;
    pixel_stream_t pixel_i;
    byte_t         op_code_i;
    logic          op_code_valid_i;
    logic          operand_valid_i;
    int            operand_count_i;
    byte_t         response_o;
    logic          response_valid_o;

    integer seed;
    int     check_count;
    int     error_count;

    byte_t frame_model [CAPTURE_SIZE];     // Expected bytes of the last frame sent
    byte_t captured_model [CAPTURE_SIZE];  // Expected buffer contents
    byte_t response_samples [$];
    logic  model_armed;
    logic  model_capturing;
    int    model_read_count;               // Operands consumed since the last capture

    camera UUT (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel_i),
        .op_code_i         (op_code_i),
        .op_code_valid_i   (op_code_valid_i),
        .operand_valid_i   (operand_valid_i),
        .operand_count_i   (operand_count_i),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o)
    );

    always #10 clock_spi_in = ~clock_spi_in;

    function automatic byte_t to_rgb332(input color_t red, input color_t green,
                                        input color_t blue);
        return byte_t'((int'(red) / 128) * 32 + (int'(green) / 128) * 4 + int'(blue) / 256);
    endfunction

    function automatic logic in_window(input int col, input int line);
        return (col >= int'(CROP_X_START)) && (col < int'(CROP_X_END)) &&
               (line >= int'(CROP_Y_START)) && (line < int'(CROP_Y_END));
    endfunction

    // Raster order inside the crop window
    function automatic index_t window_index(input int col, input int line);
        return index_t'((line - int'(CROP_Y_START)) * int'(CROP_X_END - CROP_X_START) +
                        (col - int'(CROP_X_START)));
    endfunction

    task automatic check_bit(input string name, input logic actual, input logic expected);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED: %s is 0x%02h, expected 0x%02h", name, actual, expected);
        end
    endtask

    task automatic print_counts;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
    endtask

    task automatic abort_on_timeout(input string what);
        error_count++;
        $display("Timeout while waiting for %s", what);
        print_counts();
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clock_spi_in);
    endtask

    task automatic wait_for_response_valid(input logic level, input string what);
        int cycles;
        cycles = 0;
        while ((response_valid_o !== level) && (cycles < RESPONSE_TIMEOUT)) begin
            @(negedge clock_spi_in);
            cycles++;
        end
        if (response_valid_o !== level) begin
            abort_on_timeout(what);
        end
    endtask

    // Response for each operand is sampled before its strobe
    task automatic host_command(input byte_t opcode, input int operands);
        int k;
        @(negedge clock_spi_in);
        op_code_i       = opcode;
        op_code_valid_i = 1'b1;
        operand_valid_i = 1'b0;
        operand_count_i = 0;
        response_samples.delete();
        if (opcode == OP_CAPTURE) begin
            wait_cycles(4);
            check_bit("response_valid_o", response_valid_o, 1'b0);
        end else begin
            wait_for_response_valid(1'b1, "response_valid_o to rise");
        end
        for (k = 0; k < operands; k++) begin
            @(negedge clock_spi_in);
            operand_count_i = k;
            wait_cycles(4);
            check_bit("response_valid_o", response_valid_o, 1'b1);
            response_samples.push_back(response_o);
            operand_valid_i = 1'b1;
            wait_cycles(4);
            operand_valid_i = 1'b0;
        end
        op_code_valid_i = 1'b0;
        wait_for_response_valid(1'b0, "response_valid_o to fall");
    endtask

    task automatic send_capture;
        if (!model_armed && !model_capturing) begin
            model_armed      = 1'b1;           // Only accepted when idle
            model_read_count = 0;
        end
        host_command(OP_CAPTURE, 0);
    endtask

    task automatic check_bytes_available;
        buffer_addr_t remaining;
        remaining = CAPTURE_SIZE - buffer_addr_t'(model_read_count);
        host_command(OP_BYTES_AVAILABLE, 2);
        check_byte("response_o (count high)", response_samples[0], remaining[15:8]);
        check_byte("response_o (count low)", response_samples[1], remaining[7:0]);
    endtask

    // Reads in random chunks with a count query after each one
    task automatic read_buffer(input int total);
        int done;
        int chunk;
        int k;
        done = 0;
        while (done < total) begin
            chunk = 1 + {$random(seed)} % 24;
            if (chunk > total - done) begin
                chunk = total - done;
            end
            host_command(OP_READ_DATA, chunk);
            for (k = 0; k < chunk; k++) begin
                check_byte("response_o", response_samples[k],
                           captured_model[index_t'(model_read_count)]);
                model_read_count++;
            end
            done += chunk;
            check_bytes_available();
        end
    endtask

    task automatic send_frame;
        int line;
        int col;
        int gap;
        if (model_armed) begin
            model_armed     = 1'b0;
            model_capturing = 1'b1;            // This frame gets captured
        end
        @(negedge clock_spi_in);
        pixel_i             = '0;
        pixel_i.frame_valid = 1'b1;
        wait_cycles(2);
        for (line = 0; line < FRAME_HEIGHT; line++) begin
            for (col = 0; col < FRAME_WIDTH; col++) begin
                pixel_i.red        = color_t'($random(seed));
                pixel_i.green      = color_t'($random(seed));
                pixel_i.blue       = color_t'($random(seed));
                pixel_i.line_valid = 1'b1;
                if (in_window(col, line)) begin
                    frame_model[window_index(col, line)] =
                        to_rgb332(pixel_i.red, pixel_i.green, pixel_i.blue);
                end
                @(negedge clock_spi_in);
            end
            pixel_i.line_valid = 1'b0;
            gap = 1 + {$random(seed)} % 4;     // Line blanking
            wait_cycles(gap);
        end
        pixel_i.frame_valid = 1'b0;
        gap = 12 + {$random(seed)} % 16;       // Frame blanking
        wait_cycles(gap);
        if (model_capturing) begin
            captured_model  = frame_model;
            model_capturing = 1'b0;
        end
    endtask

    initial begin
        seed             = 32'h8bf9_ac20;
        check_count      = 0;
        error_count      = 0;
        model_armed      = 1'b0;
        model_capturing  = 1'b0;
        model_read_count = 0;

        clock_spi_in      = 1'b0;
        mipi_byte_reset_n = 1'b0;
        pixel_i           = '0;
        op_code_i         = '0;
        op_code_valid_i   = 1'b0;
        operand_valid_i   = 1'b0;
        operand_count_i   = 0;
        wait_cycles(8);
        mipi_byte_reset_n = 1'b1;
        wait_cycles(2);

        // Quiet after reset, whole buffer still unread
        check_bit("response_valid_o", response_valid_o, 1'b0);
        check_bytes_available();

        send_capture();
        send_capture();                        // Already armed
        fork
            send_frame();
            begin
                wait_cycles(200);
                send_capture();                // Capture in progress
            end
        join
        send_frame();                          // Must not replace the captured frame

        read_buffer(int'(CAPTURE_SIZE) / 2);
        send_frame();                          // No capture requested
        read_buffer(int'(CAPTURE_SIZE) / 2);

        // Second capture restarts the read position
        send_capture();
        check_bytes_available();
        send_frame();
        read_buffer(int'(CAPTURE_SIZE));

        print_counts();
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== capture_ctrl.sv ====
`timescale 1ns/1ps

module capture_ctrl import camera_pkg::*; (
    input  logic         clock_spi_in,
    input  logic         mipi_byte_reset_n,
    input  byte_t        op_code_i,
    input  logic         op_code_valid_i,
    input  logic         operand_valid_i,
    input  int           operand_count_i,
    input  logic         cropped_frame_valid_i,
    input  byte_t        read_data_i,
    output buffer_addr_t read_address_o,
    output logic         capture_active_o,
    output byte_t        response_o,
    output logic         response_valid_o
);

    ctrl_state_t  state;
    buffer_addr_t bytes_read;
    buffer_addr_t bytes_remaining;
    logic         last_operand_valid;
    logic         operand_rise;
    logic         capture_request;
    logic [1:0]   frame_edge;     // Previous and current frame valid

    assign bytes_remaining = CAPTURE_SIZE - bytes_read;
    assign operand_rise    = operand_valid_i && !last_operand_valid;
    assign capture_request = op_code_valid_i && (op_code_i == OP_CAPTURE);

    assign read_address_o   = bytes_read;
    assign capture_active_o = (state == CTRL_CAPTURING);

    // Capture FSM, follows the cropped frame through the edge monitor
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state      <= CTRL_IDLE;
            frame_edge <= 2'b00;
        end else begin
            frame_edge <= {frame_edge[0], cropped_frame_valid_i};

            case (state)
                CTRL_IDLE: begin
                    if (capture_request) begin
                        state <= CTRL_ARMED;
                    end
                end
                CTRL_ARMED: begin
                    if (frame_edge == 2'b01) begin
                        state <= CTRL_CAPTURING;   // Frame start
                    end
                end
                CTRL_CAPTURING: begin
                    if (frame_edge == 2'b10) begin
                        state <= CTRL_IDLE;        // Frame end
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // Host command decode and responses
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            bytes_read         <= '0;
            last_operand_valid <= 1'b0;
            response_o         <= '0;
            response_valid_o   <= 1'b0;
        end else begin
            last_operand_valid <= operand_valid_i;

            if (op_code_valid_i) begin
                case (op_code_i)
                    OP_CAPTURE: begin
                        if (state == CTRL_IDLE) begin
                            bytes_read <= '0;      // New capture, restart reading
                        end
                    end
                    OP_BYTES_AVAILABLE: begin
                        if (operand_count_i == 0) begin
                            response_o <= bytes_remaining[15:8];
                        end else if (operand_count_i == 1) begin
                            response_o <= bytes_remaining[7:0];
                        end
                        response_valid_o <= 1'b1;
                    end
                    OP_READ_DATA: begin
                        response_o       <= read_data_i;
                        response_valid_o <= 1'b1;
                        if (operand_rise) begin
                            bytes_read <= bytes_read + 16'd1;
                        end
                    end
                    default: begin
                        response_valid_o <= 1'b0;  // Unknown opcode
                    end
                endcase
            end else begin
                response_valid_o <= 1'b0;
            end
        end
    end

    // A response only ever follows an active command
    a_response_after_command: assert property (
        @(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        response_valid_o |-> $past(op_code_valid_i)
    );

    // Capture always passes through the armed state
    a_idle_not_to_capturing: assert property (
        @(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        (state == CTRL_IDLE) |=> (state != CTRL_CAPTURING)
    );

endmodule

// ==== frame_crop.sv ====
`timescale 1ns/1ps

module frame_crop import camera_pkg::*; (
    input  logic          clock_spi_in,
    input  logic          mipi_byte_reset_n,
    input  pixel_stream_t pixel_i,
    output pixel_stream_t pixel_o
);

    logic [15:0]   x_count;      // Column of the current pixel
    logic [15:0]   y_count;      // Line of the current pixel
    logic          last_line_valid;
    logic          pixel_valid;
    logic          line_end;
    logic          in_window;
    pixel_stream_t pixel_q;

    assign pixel_valid = pixel_i.line_valid && pixel_i.frame_valid;
    assign line_end    = last_line_valid && !pixel_i.line_valid;

    assign in_window = (x_count >= CROP_X_START) && (x_count < CROP_X_END) &&
                       (y_count >= CROP_Y_START) && (y_count < CROP_Y_END);

    // Column and line counters
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count         <= '0;
            y_count         <= '0;
            last_line_valid <= 1'b0;
        end else begin
            last_line_valid <= pixel_i.line_valid;

            if (!pixel_i.line_valid) begin
                x_count <= '0;                 // End of line
            end else if (pixel_valid) begin
                x_count <= x_count + 16'd1;
            end

            if (!pixel_i.frame_valid) begin
                y_count <= '0;
            end else if (line_end) begin
                y_count <= y_count + 16'd1;
            end
        end
    end

    // Output register, colours pass unchanged
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            pixel_q <= '0;
        end else begin
            pixel_q.red         <= pixel_i.red;
            pixel_q.green       <= pixel_i.green;
            pixel_q.blue        <= pixel_i.blue;
            pixel_q.frame_valid <= pixel_i.frame_valid;
            pixel_q.line_valid  <= pixel_i.line_valid && in_window;
        end
    end

    assign pixel_o = pixel_q;

    // Cropped line valid stays inside the frame
    a_line_in_frame: assert property (
        @(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        pixel_o.line_valid |-> pixel_o.frame_valid
    );

endmodule

// ==== image_buffer.sv ====
`timescale 1ns/1ps

module image_buffer import camera_pkg::*; (
    input  logic          clock_spi_in,
    input  buffer_write_t write_i,
    input  buffer_addr_t  read_address_i,
    output byte_t         read_data_o
);

    byte_t memory [CAPTURE_SIZE];

    logic [BUFFER_ADDR_BITS-1:0] write_index;
    logic [BUFFER_ADDR_BITS-1:0] read_index;

    assign write_index = write_i.address[BUFFER_ADDR_BITS-1:0];
    assign read_index  = read_address_i[BUFFER_ADDR_BITS-1:0];

    always_ff @(posedge clock_spi_in) begin
        if (write_i.enable) begin
            memory[write_index] <= write_i.data;
        end
    end

    // Registered read, one cycle behind the address
    always_ff @(posedge clock_spi_in) begin
        read_data_o <= memory[read_index];
    end

endmodule

// ==== pixel_packer.sv ====
`timescale 1ns/1ps

module pixel_packer import camera_pkg::*; (
    input  logic          clock_spi_in,
    input  logic          mipi_byte_reset_n,
    input  pixel_stream_t pixel_i,
    input  logic          capture_active_i,
    output buffer_write_t write_o
);

    buffer_addr_t  pixel_count;  // Cropped pixels seen in this frame
    logic          pixel_valid;
    byte_t         rgb332;
    buffer_write_t write_q;

    assign pixel_valid = pixel_i.line_valid && pixel_i.frame_valid;

    // Top bits of each channel, blue gets two
    assign rgb332 = {pixel_i.red[9:7], pixel_i.green[9:7], pixel_i.blue[9:8]};

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            pixel_count <= '0;
        end else if (!pixel_i.frame_valid) begin
            pixel_count <= '0;               // Restart between frames
        end else if (pixel_valid) begin
            pixel_count <= pixel_count + 16'd1;
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            write_q <= '0;
        end else begin
            write_q.enable  <= pixel_valid && capture_active_i;
            write_q.address <= pixel_count;
            write_q.data    <= rgb332;
        end
    end

    assign write_o = write_q;

    // A full frame never runs past the buffer
    a_write_in_range: assert property (
        @(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        write_o.enable |-> (write_o.address < CAPTURE_SIZE)
    );

endmodule
